// ==== verilog/obj_pkg.sv ====
// Sprite line renderer shared types, FSM states and bus widths
package obj_pkg;

    localparam int ROM_AW = 18;                 // Word address, bank on top of offset
    localparam int BUF_AW = 9;                  // One scan line of buffer
    localparam logic [3:0] COLOR_TRANSP = 4'hF; // Never written

    // One sprite attribute table entry
    typedef struct packed {
        logic [8:0]        top;     // First line covered
        logic [7:0]        height;  // Lines covered
        logic [BUF_AW-1:0] xpos;
        logic [15:0]       base;    // ROM word offset of row 0
        logic [7:0]        pitch;   // Words per row
        logic [1:0]        bank;
        logic [1:0]        prio;
        logic              shadow;
        logic [6:0]        pal;
        logic [4:0]        hzoom;
        logic              hflip;
        logic              backwd;  // Draw leftward from xpos
        logic              eol;     // End of list, entry itself skipped
    } obj_entry_t;

    // Draw command, scanner to drawer
    typedef struct packed {
        logic [BUF_AW-1:0] xpos;
        logic [15:0]       offset;  // Word offset of the row on this line
        logic [1:0]        bank;
        logic [1:0]        prio;
        logic              shadow;
        logic [6:0]        pal;
        logic [4:0]        hzoom;
        logic              hflip;
        logic              backwd;
    } obj_cmd_t;

    typedef struct packed {
        logic [6:0] pal;
        logic       shadow;
        logic [1:0] prio;
        logic [3:0] color;
    } obj_pixel_t;

    // Cleared buffer word
    localparam obj_pixel_t PIX_CLEAR = '{pal: 7'd0, shadow: 1'b0, prio: 2'd0,
                                         color: COLOR_TRANSP};

    typedef enum logic [2:0] {S_IDLE, S_READ, S_CHECK, S_ISSUE, S_WAIT, S_DONE} scan_state_t;

    typedef enum logic [1:0] {D_IDLE, D_FETCH, D_DRAW} draw_state_t;

endpackage

// ==== verilog/obj_scan.sv ====
// Sprite scanner, walks the attribute table and issues draw commands for the next line
`timescale 1ns/1ns

module obj_scan #(
    parameter int OBJ_COUNT = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           hstart,
    input  logic [8:0]                     vrender,
    input  logic                           tbl_we,
    input  logic [$clog2(OBJ_COUNT)-1:0]   tbl_addr,
    input  obj_pkg::obj_entry_t            tbl_din,
    input  logic                           busy,
    output logic                           start,
    output obj_pkg::obj_cmd_t              cmd
);

    localparam int IDX_W = $clog2(OBJ_COUNT);

    obj_pkg::obj_entry_t  tbl [OBJ_COUNT];  // Attribute table RAM
    obj_pkg::obj_entry_t  ent;              // Entry under test
    obj_pkg::scan_state_t state;
    logic [IDX_W-1:0]     idx;              // Entry index
    logic [8:0]           line;             // Line being prepared
    logic [8:0]           row;              // Row of the sprite on that line
    logic                 on_line;
    logic                 last_idx;
    logic [15:0]          row_offset;

    // Write port from the host, scan read port registered
    always_ff @(posedge clk) begin
        if (tbl_we) begin
            tbl[tbl_addr] <= tbl_din;
        end
        ent <= tbl[idx];
    end

    assign row        = line - ent.top;              // Wraps high when above top
    assign on_line    = row < {1'b0, ent.height};
    assign row_offset = ent.base + 16'(ent.pitch) * 16'(row[7:0]);
    assign last_idx   = idx == IDX_W'(OBJ_COUNT - 1);

    // Entry walk, 2 cycles per entry plus the wait on the drawer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= obj_pkg::S_IDLE;
            idx   <= '0;
            start <= 1'b0;
        end else if (hstart) begin
            state <= obj_pkg::S_READ;                 // New line from entry 0
            idx   <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;                            // Single cycle pulse
            case (state)
                obj_pkg::S_READ: begin
                    state <= obj_pkg::S_CHECK;        // RAM data ready next cycle
                end
                obj_pkg::S_CHECK: begin
                    if (ent.eol) begin
                        state <= obj_pkg::S_DONE;
                    end else if (on_line) begin
                        state <= obj_pkg::S_ISSUE;
                    end else if (last_idx) begin
                        state <= obj_pkg::S_DONE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= obj_pkg::S_READ;
                    end
                end
                obj_pkg::S_ISSUE: begin
                    // Drawer free and no start of ours still in flight
                    if (!busy && !start) begin
                        start <= 1'b1;
                        state <= obj_pkg::S_WAIT;
                    end
                end
                obj_pkg::S_WAIT: begin
                    if (last_idx) begin
                        state <= obj_pkg::S_DONE;
                    end else begin
                        idx   <= idx + 1'b1;          // Scan on while the drawer works
                        state <= obj_pkg::S_READ;
                    end
                end
                obj_pkg::S_IDLE, obj_pkg::S_DONE: begin
                    state <= state;                   // Hold until hstart
                end
                default: state <= obj_pkg::S_IDLE;
            endcase
        end
    end

    // Line latch and command build
    always_ff @(posedge clk) begin
        if (hstart) begin
            line <= vrender;
        end
        if (state == obj_pkg::S_CHECK && on_line) begin
            cmd.xpos   <= ent.xpos;
            cmd.offset <= row_offset;
            cmd.bank   <= ent.bank;
            cmd.prio   <= ent.prio;
            cmd.shadow <= ent.shadow;
            cmd.pal    <= ent.pal;
            cmd.hzoom  <= ent.hzoom;
            cmd.hflip  <= ent.hflip;
            cmd.backwd <= ent.backwd;
        end
    end

endmodule

// ==== verilog/obj_draw.sv ====
// Sprite drawer, fetches ROM words and writes zoomed, flipped pixels to the line buffer
`timescale 1ns/1ns

module obj_draw #(
    parameter logic [obj_pkg::BUF_AW-1:0] BUF_LEFT = 9'h94
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        hstart,
    input  logic                        start,
    input  obj_pkg::obj_cmd_t           cmd,
    output logic                        busy,
    output logic                        rom_cs,
    output logic [obj_pkg::ROM_AW-1:0]  rom_addr,
    input  logic                        rom_ok,
    input  logic [31:0]                 rom_data,
    output logic                        bf_we,
    output logic [obj_pkg::BUF_AW-1:0]  bf_addr,
    output obj_pkg::obj_pixel_t         bf_data
);

    obj_pkg::draw_state_t         state;
    obj_pkg::obj_cmd_t            cq;       // Latched command
    logic [15:0]                  word;     // Current ROM word offset
    logic [31:0]                  pxl;      // Pixel shifter
    logic [2:0]                   cnt;      // Pixel within word
    logic [5:0]                   hzacc;    // Zoom accumulator
    logic [6:0]                   hz_sum;
    logic                         hz_skip;  // Pixel eaten by zoom
    logic [obj_pkg::BUF_AW-1:0]   xcur;     // Next buffer address
    logic [obj_pkg::BUF_AW-1:0]   xstep;
    logic                         fresh;    // First cycle of a request
    logic [3:0]                   pix_c;
    logic                         transp;
    logic                         lim_lo;
    logic                         lim_hi;
    logic                         take_cmd;
    logic                         take_word;
    logic                         drawing;
    logic                         put_pix;
    logic                         hit_lim;
    logic                         word_end;

    assign rom_addr = {cq.bank, word};

    // Top nibble first, bottom first when flipped
    assign pix_c  = cq.hflip ? pxl[3:0] : pxl[31:28];
    assign transp = pix_c == obj_pkg::COLOR_TRANSP;

    assign hz_sum  = {1'b0, hzacc} + {2'b00, cq.hzoom};
    assign hz_skip = hz_sum[6];                          // Carry out drops the pixel

    assign xstep  = cq.backwd ? '1 : obj_pkg::BUF_AW'(1);  // -1 or +1
    assign lim_lo = cq.backwd && (xcur < BUF_LEFT);       // Left of the visible area
    assign lim_hi = !cq.backwd && (xcur == '1);           // Last column, stop after it

    assign take_cmd  = (state == obj_pkg::D_IDLE) && start;
    assign take_word = (state == obj_pkg::D_FETCH) && rom_cs && rom_ok && !fresh;
    assign drawing   = state == obj_pkg::D_DRAW;
    assign put_pix   = drawing && !hz_skip && !lim_lo;
    assign hit_lim   = drawing && !hz_skip && (lim_lo || lim_hi);
    assign word_end  = drawing && (cnt == 3'd7);

    // Control FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= obj_pkg::D_IDLE;
            busy   <= 1'b0;
            rom_cs <= 1'b0;
            bf_we  <= 1'b0;
            fresh  <= 1'b0;
        end else if (hstart) begin
            state  <= obj_pkg::D_IDLE;                  // Line over, drop the sprite
            busy   <= 1'b0;
            rom_cs <= 1'b0;
            bf_we  <= 1'b0;
            fresh  <= 1'b0;
        end else begin
            bf_we <= put_pix && !transp;                // F is never written
            fresh <= 1'b0;
            case (state)
                obj_pkg::D_IDLE: begin
                    if (start) begin
                        busy   <= 1'b1;
                        rom_cs <= 1'b1;
                        fresh  <= 1'b1;
                        state  <= obj_pkg::D_FETCH;
                    end
                end
                obj_pkg::D_FETCH: begin
                    if (take_word) begin
                        rom_cs <= 1'b0;
                        state  <= obj_pkg::D_DRAW;
                    end
                end
                obj_pkg::D_DRAW: begin
                    if (hit_lim || (word_end && transp)) begin
                        busy  <= 1'b0;                  // Edge reached or sprite ended
                        state <= obj_pkg::D_IDLE;
                    end else if (word_end) begin
                        rom_cs <= 1'b1;                 // Next word
                        fresh  <= 1'b1;
                        state  <= obj_pkg::D_FETCH;
                    end
                end
                default: state <= obj_pkg::D_IDLE;
            endcase
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (take_cmd) begin
            cq    <= cmd;
            word  <= cmd.offset;
            xcur  <= cmd.xpos;
            hzacc <= {cmd.hzoom[3:0], 2'b00};
        end
        if (take_word) begin
            pxl <= rom_data;
            cnt <= '0;
        end
        if (drawing) begin
            pxl   <= cq.hflip ? (pxl >> 4) : (pxl << 4);
            cnt   <= cnt + 1'b1;
            hzacc <= hz_sum[5:0];
        end
        if (word_end) begin
            word <= word + (cq.hflip ? 16'hFFFF : 16'h0001);  // Flip walks words down
        end
        if (put_pix) begin
            bf_addr <= xcur;
            bf_data <= '{pal: cq.pal, shadow: cq.shadow, prio: cq.prio, color: pix_c};
            xcur    <= xcur + xstep;
        end
    end

endmodule

// ==== verilog/obj_linebuf.sv ====
// Double line buffer, drawn in the back half and read and cleared from the front half
`timescale 1ns/1ns

module obj_linebuf (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        hstart,
    input  logic                        we,
    input  logic [obj_pkg::BUF_AW-1:0]  waddr,
    input  obj_pkg::obj_pixel_t         wdata,
    input  logic [obj_pkg::BUF_AW-1:0]  raddr,
    output obj_pkg::obj_pixel_t         rdata
);

    localparam int DEPTH = 1 << obj_pkg::BUF_AW;

    logic back;     // Half being drawn
    logic rd_half;  // Half that fed the last read

    // Swap at line start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            back    <= 1'b0;
            rd_half <= 1'b1;
        end else begin
            if (hstart) begin
                back <= ~back;
            end
            rd_half <= ~back;    // Front half at read time
        end
    end

    // Two identical halves, one write port each
    for (genvar h = 0; h < 2; h++) begin : g_half
        obj_pkg::obj_pixel_t        mem [DEPTH];
        obj_pkg::obj_pixel_t        rd_q;
        logic                       is_back;
        logic                       h_we;
        logic [obj_pkg::BUF_AW-1:0] h_addr;
        obj_pkg::obj_pixel_t        h_din;

        assign is_back = back == 1'(h);

        // Back half takes drawer writes
        // Front half rewrites each read location as transparent
        assign h_we   = is_back ? we : 1'b1;
        assign h_addr = is_back ? waddr : raddr;
        assign h_din  = is_back ? wdata : obj_pkg::PIX_CLEAR;

        always_ff @(posedge clk) begin
            if (h_we) begin
                mem[h_addr] <= h_din;
            end
            rd_q <= mem[raddr];     // Old data, clear lands on the same edge
        end
    end

    assign rdata = rd_half ? g_half[1].rd_q : g_half[0].rd_q;

endmodule

// ==== verilog/obj_line_top.sv ====
// Sprite line renderer top, scanner feeding drawer feeding the double line buffer
`timescale 1ns/1ns

module obj_line_top #(
    parameter int                         OBJ_COUNT = 16,
    parameter logic [obj_pkg::BUF_AW-1:0] BUF_LEFT  = 9'h94
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hstart,
    input  logic [8:0]                    vrender,
    input  logic [obj_pkg::BUF_AW-1:0]    hdump,
    // Attribute table port
    input  logic                          tbl_we,
    input  logic [$clog2(OBJ_COUNT)-1:0]  tbl_addr,
    input  obj_pkg::obj_entry_t           tbl_din,
    // Graphics ROM
    output logic                          rom_cs,
    output logic [obj_pkg::ROM_AW-1:0]    rom_addr,
    input  logic                          rom_ok,
    input  logic [31:0]                   rom_data,
    // Pixel out, one cycle after hdump
    output obj_pkg::obj_pixel_t           pix
);

    logic                        start;
    logic                        busy;
    obj_pkg::obj_cmd_t           cmd;
    logic                        bf_we;
    logic [obj_pkg::BUF_AW-1:0]  bf_addr;
    obj_pkg::obj_pixel_t         bf_data;

    obj_scan #(.OBJ_COUNT(OBJ_COUNT)) u_scan (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .vrender  (vrender),
        .tbl_we   (tbl_we),
        .tbl_addr (tbl_addr),
        .tbl_din  (tbl_din),
        .busy     (busy),
        .start    (start),
        .cmd      (cmd)
    );

    obj_draw #(.BUF_LEFT(BUF_LEFT)) u_draw (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .start    (start),
        .cmd      (cmd),
        .busy     (busy),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .bf_we    (bf_we),
        .bf_addr  (bf_addr),
        .bf_data  (bf_data)
    );

    obj_linebuf u_buf (
        .clk    (clk),
        .rst    (rst),
        .hstart (hstart),
        .we     (bf_we),
        .waddr  (bf_addr),
        .wdata  (bf_data),
        .raddr  (hdump),
        .rdata  (pix)
    );

endmodule

// ==== sim/obj_clk_gen.sv ====
// Testbench clock and reset source, 20 ns period, reset held for 3 cycles
`timescale 1ns/1ns

module obj_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;                 // Released between edges
    end

    always #10 clk = ~clk;

endmodule

// ==== sim/obj_rom_pattern.svh ====
// Graphics ROM test pattern, one word of eight 4-bit pixels per 18-bit word address

function automatic logic [31:0] rom_word(input logic [17:0] a);
    logic [31:0] w;
    w = ({14'd0, a} * 32'h2C9277B5) ^ {a[13:0], a};   // Mix of the whole address
    if (a[1:0] == 2'b11) begin
        w[3:0]   = 4'hF;                                // Both end pixels transparent
        w[31:28] = 4'hF;
    end else begin
        if (w[3:0] == 4'hF)   w[3:0]   = 4'hE;          // Keep the sprite going
        if (w[31:28] == 4'hF) w[31:28] = 4'hE;
    end
    if (a[0]) begin
        w[19:16] = 4'hF;                                // Hole inside the word
    end
    return w;
endfunction

// ==== sim/obj_line_checker.sv ====
// Line checker, predicts each rendered line from the mirrored table and compares pixels
`timescale 1ns/1ns

module obj_line_checker #(
    parameter int         OBJ_COUNT = 16,
    parameter logic [8:0] BUF_LEFT  = 9'h94
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          tbl_we,
    input  logic [$clog2(OBJ_COUNT)-1:0]  tbl_addr,
    input  obj_pkg::obj_entry_t           tbl_din,
    input  logic                          hstart,
    input  logic [8:0]                    vrender,
    input  logic [8:0]                    hdump,
    input  logic                          cmp_en,
    input  obj_pkg::obj_pixel_t           pix,
    output int                            errors,
    output int                            checks
);

    `include "obj_rom_pattern.svh"

    obj_pkg::obj_entry_t tbl [OBJ_COUNT];   // Copy of the attribute table
    obj_pkg::obj_pixel_t exp_pix [512];     // Predicted front half
    int                  hs_count;
    logic                pend;
    logic [8:0]          pend_addr;

    // Walk one sprite row, word by word, pixel by pixel
    task automatic draw_sprite(input obj_pkg::obj_entry_t e, input logic [15:0] offset);
        logic [8:0]  x;
        logic [5:0]  acc;
        logic [6:0]  sum;
        logic [15:0] w;
        logic [31:0] data;
        logic [3:0]  c;
        logic        done;
        int          k;
        x    = e.xpos;
        acc  = {e.hzoom[3:0], 2'b00};
        w    = offset;
        done = 1'b0;
        while (!done) begin
            data = rom_word({e.bank, w});
            for (k = 0; k < 8 && !done; k++) begin
                c   = e.hflip ? data[4*k +: 4] : data[28-4*k +: 4];
                sum = {1'b0, acc} + {2'b00, e.hzoom};
                acc = sum[5:0];
                if (!sum[6]) begin              // Carry means the pixel is dropped
                    if (e.backwd && x < BUF_LEFT) begin
                        done = 1'b1;            // Left limit, nothing written
                    end else begin
                        if (c != 4'hF) begin
                            exp_pix[x] = {e.pal, e.shadow, e.prio, c};
                        end
                        if (!e.backwd && x == 9'h1FF) done = 1'b1;
                        x = e.backwd ? x - 9'd1 : x + 9'd1;
                    end
                end
                if (k == 7 && c == 4'hF) done = 1'b1;   // Transparent tail ends it
            end
            w = e.hflip ? w - 16'd1 : w + 16'd1;
        end
    endtask

    task automatic predict_line(input logic [8:0] v);
        logic [8:0]  row;
        logic        stop;
        int          i;
        for (i = 0; i < 512; i++) exp_pix[i] = 14'h000F;   // Empty is colour F
        stop = 1'b0;
        for (i = 0; i < OBJ_COUNT && !stop; i++) begin
            if (tbl[i].eol) begin
                stop = 1'b1;
            end else begin
                row = v - tbl[i].top;
                if (row < {1'b0, tbl[i].height}) begin
                    draw_sprite(tbl[i], tbl[i].base + 16'(tbl[i].pitch) * 16'(row[7:0]));
                end
            end
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            errors   <= 0;
            checks   <= 0;
            hs_count <= 0;
            pend     <= 1'b0;
        end else begin
            if (tbl_we) tbl[tbl_addr] = tbl_din;
            if (hstart) begin
                hs_count <= hs_count + 1;
                if (hs_count % 2 == 0) predict_line(vrender);  // Drawing half of the pair
            end
            if (pend) begin
                checks <= checks + 1;
                if (pix !== exp_pix[pend_addr]) begin
                    errors <= errors + 1;
                    $display("Mismatch at %0t ns: pix[%0d] expected %h actual %h",
                             $time, pend_addr, exp_pix[pend_addr], pix);
                end
                exp_pix[pend_addr] = 14'h000F;   // Read clears it
            end
            pend      <= cmp_en;
            pend_addr <= hdump;
        end
    end

endmodule

// ==== sim/obj_line_tb.sv ====
// Sprite line renderer testbench, table driven lines against a random latency ROM
`timescale 1ns/1ns

module obj_line_tb;

    localparam int         OBJ_COUNT = 16;
    localparam logic [8:0] BUF_LEFT  = 9'h94;
    localparam int         N_ROWS    = 12;

    typedef struct packed {
        logic [3:0]          addr;
        obj_pkg::obj_entry_t ent;
        logic [8:0]          line;
        logic                run;      // Render a line after this write
        logic                reread;   // Sweep the line a second time
    } row_t;

    logic                clk, rst, hstart, tbl_we, rom_cs, rom_ok, cmp_en;
    logic [8:0]          vrender, hdump;
    logic [3:0]          tbl_addr;
    obj_pkg::obj_entry_t tbl_din;
    logic [17:0]         rom_addr;
    logic [31:0]         rom_data;
    obj_pkg::obj_pixel_t pix;
    int                  errors, checks, rom_cnt;
    logic                rom_pend;
    row_t                stim [N_ROWS];

    `include "obj_rom_pattern.svh"

    obj_clk_gen clkgen (.clk(clk), .rst(rst));

    obj_line_top #(.OBJ_COUNT(OBJ_COUNT), .BUF_LEFT(BUF_LEFT)) UUT (
        .clk(clk), .rst(rst), .hstart(hstart), .vrender(vrender), .hdump(hdump),
        .tbl_we(tbl_we), .tbl_addr(tbl_addr), .tbl_din(tbl_din),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_ok(rom_ok), .rom_data(rom_data),
        .pix(pix)
    );

    obj_line_checker #(.OBJ_COUNT(OBJ_COUNT), .BUF_LEFT(BUF_LEFT)) chk (
        .clk(clk), .rst(rst), .tbl_we(tbl_we), .tbl_addr(tbl_addr), .tbl_din(tbl_din),
        .hstart(hstart), .vrender(vrender), .hdump(hdump), .cmp_en(cmp_en), .pix(pix),
        .errors(errors), .checks(checks)
    );

    function automatic obj_pkg::obj_entry_t sprite_entry(
        input logic [8:0] top, input logic [7:0] height, input logic [8:0] xpos,
        input logic [15:0] base, input logic [7:0] pitch, input logic [1:0] bank,
        input logic [6:0] pal, input logic [4:0] hzoom, input logic hflip,
        input logic backwd, input logic eol);
        return '{top: top, height: height, xpos: xpos, base: base, pitch: pitch,
                 bank: bank, prio: pal[1:0], shadow: pal[2], pal: pal, hzoom: hzoom,
                 hflip: hflip, backwd: backwd, eol: eol};
    endfunction

    // ROM with 1 to 4 cycles of wait per request
    always @(negedge clk) begin
        if (rst || !rom_cs) begin
            rom_ok   = 1'b0;
            rom_pend = 1'b0;
        end else if (!rom_ok) begin
            if (!rom_pend) begin
                rom_pend = 1'b1;
                rom_cnt  = 1 + int'($urandom % 4);
            end
            rom_cnt = rom_cnt - 1;
            if (rom_cnt == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_word(rom_addr);
            end
        end
    end

    task automatic write_entry(input logic [3:0] a, input obj_pkg::obj_entry_t e);
        tbl_we   = 1'b1;
        tbl_addr = a;
        tbl_din  = e;
        @(negedge clk);
        tbl_we   = 1'b0;
    endtask

    task automatic pulse_hstart(input logic [8:0] v);
        hstart  = 1'b1;
        vrender = v;
        @(negedge clk);
        hstart  = 1'b0;
    endtask

    task automatic sweep(input logic check);
        cmp_en = check;
        for (int a = 0; a < 512; a++) begin
            hdump = 9'(a);
            @(negedge clk);
        end
        cmp_en = 1'b0;
        hdump  = '0;
    endtask

    task automatic run_line(input logic [8:0] v, input logic reread);
        pulse_hstart(v);                 // Draw into the back half
        repeat (1024) @(negedge clk);
        pulse_hstart(v);                 // Swap, drawn half goes to the front
        sweep(1'b1);
        if (reread) sweep(1'b1);         // Must read back empty
    endtask

    initial begin
        hstart   = 1'b0;
        vrender  = '0;
        hdump    = '0;
        tbl_we   = 1'b0;
        tbl_addr = '0;
        tbl_din  = '0;
        cmp_en   = 1'b0;
        rom_ok   = 1'b0;
        rom_data = '0;
        rom_pend = 1'b0;
        rom_cnt  = 0;
        void'($urandom(32'h65b00444));
        //                     top  hgt  xpos    base     pitch bk pal    zoom  fl bw eol
        stim[0]  = '{4'd0,  sprite_entry(10,  8, 9'h100, 16'h0010, 4, 1, 7'h11, 0,    0, 0, 0), 12, 1, 0};
        stim[1]  = '{4'd1,  sprite_entry(10,  4, 9'h120, 16'h0040, 3, 2, 7'h22, 0,    1, 0, 0), 0,  0, 0};
        stim[2]  = '{4'd2,  sprite_entry(8,   6, 9'h0C0, 16'h0080, 2, 0, 7'h33, 0,    0, 1, 0), 11, 1, 0};
        stim[3]  = '{4'd3,  sprite_entry(12,  4, 9'h160, 16'h0100, 5, 3, 7'h44, 5,    0, 0, 0), 0,  0, 0};
        stim[4]  = '{4'd4,  sprite_entry(12,  4, 9'h180, 16'h0120, 5, 1, 7'h55, 5'h13, 1, 1, 0), 13, 1, 0};
        stim[5]  = '{4'd5,  sprite_entry(14,  2, 9'h1F6, 16'h0200, 1, 2, 7'h66, 0,    0, 0, 0), 0,  0, 0};
        stim[6]  = '{4'd6,  sprite_entry(14,  2, 9'h09A, 16'h0210, 1, 0, 7'h77, 0,    0, 1, 0), 0,  0, 0};
        stim[7]  = '{4'd7,  sprite_entry(14,  2, 9'h104, 16'h0220, 1, 3, 7'h08, 0,    0, 0, 0), 14, 1, 0};
        stim[8]  = '{4'd8,  sprite_entry(100, 4, 9'h140, 16'h0300, 6, 1, 7'h19, 2,    0, 0, 0), 0,  0, 0};
        stim[9]  = '{4'd9,  sprite_entry(0,   0, 9'h000, 16'h0000, 0, 0, 7'h00, 0,    0, 0, 1), 0,  0, 0};
        stim[10] = '{4'd10, sprite_entry(90, 40, 9'h150, 16'h0400, 2, 0, 7'h2A, 0,    0, 0, 0), 101, 1, 1};
        stim[11] = '{4'd9,  sprite_entry(0,   0, 9'h000, 16'h0000, 0, 0, 7'h00, 0,    0, 0, 0), 101, 1, 0};
        while (rst) @(negedge clk);
        for (int i = 0; i < OBJ_COUNT; i++) write_entry(4'(i), '0);
        sweep(1'b0);                     // Clear the half that is drawn first
        for (int r = 0; r < N_ROWS; r++) begin
            write_entry(stim[r].addr, stim[r].ent);
            if (stim[r].run) run_line(stim[r].line, stim[r].reread);
        end
        repeat (4) @(negedge clk);
        $display("Pixels checked: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from the number of lines in the table
    initial begin
        longint lines;
        #1;
        lines = 1;
        for (int r = 0; r < N_ROWS; r++) lines += stim[r].run + stim[r].reread;
        #(lines * 2048 * 20 + 100000);
        $display("Watchdog expired, the run did not finish in time");
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== obj_line.f ====
+incdir+sim
verilog/obj_pkg.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_linebuf.sv
verilog/obj_line_top.sv
sim/obj_clk_gen.sv
sim/obj_line_checker.sv
sim/obj_line_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build the sprite line testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f obj_line.f \
    --top-module obj_line_tb -o obj_line_sim

./obj_dir/obj_line_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished"
